/* vic_bus_pkg.sv */
`default_nettype none

package vic_bus_pkg;

  // cpu side bus widths
  localparam int addr_w   = 6;  // adl is the low 6 address lines
  localparam int data_w   = 8;  // dbl data lines
  localparam int raster_w = 9;  // raster line and compare value
  localparam int border_w = 4;  // color index width

  // register map
  localparam logic [addr_w-1:0] reg_ctrl1      = 6'h11; // bit 7 is raster bit 8
  localparam logic [addr_w-1:0] reg_raster     = 6'h12; // low 8 raster bits
  localparam logic [addr_w-1:0] reg_irq_status = 6'h19; // write 1 to clear
  localparam logic [addr_w-1:0] reg_irq_enable = 6'h1a;
  localparam logic [addr_w-1:0] reg_border     = 6'h20;

  // bit positions inside the registers
  localparam int ctrl1_raster8_bit = 7;  // msb of raster in ctrl1
  localparam int irq_raster_bit    = 0;  // raster source in status and enable

  // unused bits and unmapped addresses read back as ones
  localparam logic [data_w-1:0] unused_read = 8'hff;

  // reset values
  localparam logic [border_w-1:0] border_reset     = 4'he; // light blue border
  localparam logic [raster_w-1:0] raster_cmp_reset = '0;
  localparam logic                irq_en_reset     = 1'b0; // interrupt masked

endpackage

`default_nettype wire

/* vic_video_pkg.sv */
`default_nettype none

package vic_video_pkg;

  // video standard, picked by the switch
  typedef enum logic {
    chip_ntsc = 1'b0,
    chip_pal  = 1'b1
  } chip_t;

  // clocks per line and lines per frame
  localparam logic [9:0] line_len_ntsc = 10'd520;
  localparam logic [9:0] line_len_pal  = 10'd504;
  localparam logic [8:0] lines_ntsc    = 9'd263;
  localparam logic [8:0] lines_pal     = 9'd312;

  // sync pulses sit at the start of line and frame
  localparam logic [9:0] hsync_len   = 10'd40;
  localparam logic [8:0] vsync_lines = 9'd3;

  // visible area, end is relative to line or frame length
  localparam logic [9:0] act_x_first  = 10'd64;
  localparam logic [8:0] act_y_first  = 9'd16;
  localparam logic [9:0] act_x_margin = 10'd24;
  localparam logic [8:0] act_y_margin = 9'd16;

  // display window, both limits inclusive
  localparam logic [9:0] win_x_first = 10'd128;
  localparam logic [9:0] win_x_last  = 10'd447;
  localparam logic [8:0] win_y_first = 9'd51;
  localparam logic [8:0] win_y_last  = 9'd250;

  // 16 color palette as rrggbb
  localparam logic [23:0] palette [16] = '{
    24'h000000,  // black
    24'hffffff,  // white
    24'h68372b,  // red
    24'h70a4b2,  // cyan
    24'h6f3d86,  // purple
    24'h588d43,  // green
    24'h352879,  // blue
    24'hb8c76f,  // yellow
    24'h6f4f25,  // orange
    24'h433900,  // brown
    24'h9a6759,  // light red
    24'h444444,  // dark grey
    24'h6c6c6c,  // grey
    24'h9ad284,  // light green
    24'h6c5eb5,  // light blue
    24'h959595   // light grey
  };

endpackage

`default_nettype wire

/* chip_select.sv */
`timescale 1ns/100ps
`default_nettype none

// video standard selection from the board switch
module chip_select (
  input  logic                 clk_col4x_ntsc,
  input  logic                 rst_n,
  input  logic                 standard_sw,  // asynchronous, 1 selects pal
  input  logic                 frame_start,
  output vic_video_pkg::chip_t chip
);

  logic                 sw_meta;  // first sync stage
  vic_video_pkg::chip_t pending;  // second stage, model waiting for the frame boundary

  always_ff @(posedge clk_col4x_ntsc or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta <= 1'b0;
      pending <= vic_video_pkg::chip_ntsc;
      chip    <= vic_video_pkg::chip_ntsc;  // ntsc until a switch is applied
    end else begin
      sw_meta <= standard_sw;
      pending <= vic_video_pkg::chip_t'(sw_meta);
      // change model only between frames
      // so a frame never mixes two line lengths
      if (frame_start) begin
        chip <= pending;
      end
    end
  end

endmodule

`default_nettype wire

/* raster_timing.sv */
`timescale 1ns/100ps
`default_nettype none

// beam position counters and the sync and blank decode
module raster_timing (
  input  logic                 clk_col4x_ntsc,
  input  logic                 rst_n,
  input  vic_video_pkg::chip_t chip,
  output logic [9:0]           x_pos,
  output logic [8:0]           y_pos,
  output logic                 line_start,   // pulse at x = 0
  output logic                 frame_start,  // pulse at x = 0, y = 0
  output logic                 hsync,
  output logic                 vsync,
  output logic                 active,
  output logic                 in_window
);

  logic [9:0] line_len;   // clocks per line for this model
  logic [8:0] frame_len;  // lines per frame for this model
  logic       line_end;
  logic       frame_end;
  logic       x_act;
  logic       y_act;
  logic       x_win;
  logic       y_win;

  assign line_len  = (chip == vic_video_pkg::chip_pal) ? vic_video_pkg::line_len_pal
                                                       : vic_video_pkg::line_len_ntsc;
  assign frame_len = (chip == vic_video_pkg::chip_pal) ? vic_video_pkg::lines_pal
                                                       : vic_video_pkg::lines_ntsc;

  // compare with >= so a stray count still wraps
  assign line_end  = (x_pos >= line_len - 10'd1);
  assign frame_end = (y_pos >= frame_len - 9'd1);

  always_ff @(posedge clk_col4x_ntsc or negedge rst_n) begin
    if (!rst_n) begin
      x_pos <= '0;
      y_pos <= '0;
    end else if (line_end) begin
      x_pos <= '0;
      y_pos <= frame_end ? 9'd0 : y_pos + 9'd1;  // next line or top of frame
    end else begin
      x_pos <= x_pos + 10'd1;
    end
  end

  assign line_start  = (x_pos == 10'd0);
  assign frame_start = line_start && (y_pos == 9'd0);

  // syncs are high at the start of line and frame
  assign hsync = (x_pos < vic_video_pkg::hsync_len);
  assign vsync = (y_pos < vic_video_pkg::vsync_lines);

  // visible area ends a fixed margin before the wrap
  assign x_act  = (x_pos >= vic_video_pkg::act_x_first) &&
                  (x_pos < line_len - vic_video_pkg::act_x_margin);
  assign y_act  = (y_pos >= vic_video_pkg::act_y_first) &&
                  (y_pos < frame_len - vic_video_pkg::act_y_margin);
  assign active = x_act && y_act;

  assign x_win     = (x_pos >= vic_video_pkg::win_x_first) &&
                     (x_pos <= vic_video_pkg::win_x_last);
  assign y_win     = (y_pos >= vic_video_pkg::win_y_first) &&
                     (y_pos <= vic_video_pkg::win_y_last);
  assign in_window = x_win && y_win;  // same for both models

endmodule

`default_nettype wire

/* vic_registers.sv */
`timescale 1ns/100ps
`default_nettype none

// cpu register file and raster interrupt
module vic_registers (
  input  logic                                clk_col4x_ntsc,
  input  logic                                rst_n,
  input  logic                                ce,            // low enables the chip
  input  logic                                rw,            // low is a write
  input  logic [vic_bus_pkg::addr_w-1:0]      adl,
  input  logic [vic_bus_pkg::data_w-1:0]      dbl,
  input  logic [vic_bus_pkg::raster_w-1:0]    y_pos,
  input  logic                                line_start,
  output logic [vic_bus_pkg::data_w-1:0]      dbo,
  output logic                                vic_write_db,  // drive dbl while high
  output logic                                irq,           // active low
  output logic [vic_bus_pkg::border_w-1:0]    border
);

  logic                             wr;          // cpu write this clock
  logic [vic_bus_pkg::raster_w-1:0] raster_cmp;  // compare line
  logic                             irq_en;
  logic                             irq_flag;
  logic                             raster_hit;

  assign wr           = !ce && !rw;
  assign vic_write_db = !ce && rw;  // read is a plain level
  assign raster_hit   = line_start && (y_pos == raster_cmp);

  always_ff @(posedge clk_col4x_ntsc or negedge rst_n) begin
    if (!rst_n) begin
      raster_cmp <= vic_bus_pkg::raster_cmp_reset;
      irq_en     <= vic_bus_pkg::irq_en_reset;
      border     <= vic_bus_pkg::border_reset;
    end else if (wr) begin
      case (adl)
        vic_bus_pkg::reg_ctrl1:      raster_cmp[8] <= dbl[vic_bus_pkg::ctrl1_raster8_bit];
        vic_bus_pkg::reg_raster:     raster_cmp[7:0] <= dbl;
        vic_bus_pkg::reg_irq_enable: irq_en <= dbl[vic_bus_pkg::irq_raster_bit];
        vic_bus_pkg::reg_border:     border <= dbl[vic_bus_pkg::border_w-1:0];
        default: ;  // status handled below, rest ignored
      endcase
    end
  end

  // raster flag
  // a match sets it, writing 1 to status clears it
  always_ff @(posedge clk_col4x_ntsc or negedge rst_n) begin
    if (!rst_n) begin
      irq_flag <= 1'b0;
    end else if (wr && adl == vic_bus_pkg::reg_irq_status &&
                 dbl[vic_bus_pkg::irq_raster_bit]) begin
      irq_flag <= 1'b0;  // ack wins over a match on the same edge
    end else if (raster_hit) begin
      irq_flag <= 1'b1;
    end
  end

  // pin follows flag and enable one clock later
  always_ff @(posedge clk_col4x_ntsc or negedge rst_n) begin
    if (!rst_n) begin
      irq <= 1'b1;
    end else begin
      irq <= !(irq_flag && irq_en);
    end
  end

  // read mux, live raster for 0x11 and 0x12
  always_comb begin
    dbo = vic_bus_pkg::unused_read;  // unmapped addresses
    case (adl)
      vic_bus_pkg::reg_ctrl1: begin
        dbo = '0;  // scroll and mode bits not implemented
        dbo[vic_bus_pkg::ctrl1_raster8_bit] = y_pos[8];
      end
      vic_bus_pkg::reg_raster: dbo = y_pos[7:0];
      vic_bus_pkg::reg_irq_status: begin
        dbo = {vic_bus_pkg::unused_read[7:4], 4'b0000};
        dbo[vic_bus_pkg::irq_raster_bit] = irq_flag;
      end
      vic_bus_pkg::reg_irq_enable: begin
        dbo = {vic_bus_pkg::unused_read[7:4], 4'b0000};
        dbo[vic_bus_pkg::irq_raster_bit] = irq_en;
      end
      vic_bus_pkg::reg_border: dbo = {vic_bus_pkg::unused_read[7:4], border};
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* pixel_color.sv */
`timescale 1ns/100ps
`default_nettype none

// color index select and palette lookup
module pixel_color #(
  parameter int rgb_w = 6  // bits per channel, 4 to 8
) (
  input  logic             clk_col4x_ntsc,
  input  logic             rst_n,
  input  logic [3:0]       border,
  input  logic [3:0]       color_nibble,  // from dbh
  input  logic             active,
  input  logic             in_window,
  output logic [rgb_w-1:0] red,
  output logic [rgb_w-1:0] green,
  output logic [rgb_w-1:0] blue
);

  logic [3:0]  color_idx;
  logic [23:0] entry;  // rrggbb from the palette

  assign color_idx = in_window ? color_nibble : border;  // border outside the window
  assign entry     = vic_video_pkg::palette[color_idx];

  // one clock behind the position, keep the top rgb_w bits of each channel
  always_ff @(posedge clk_col4x_ntsc or negedge rst_n) begin
    if (!rst_n) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else if (active) begin
      red   <= entry[23 -: rgb_w];
      green <= entry[15 -: rgb_w];
      blue  <= entry[7 -: rgb_w];
    end else begin
      red   <= '0;  // blanking
      green <= '0;
      blue  <= '0;
    end
  end

endmodule

`default_nettype wire

/* vic_top.sv */
`timescale 1ns/100ps
`default_nettype none

// board level top of the video core
module vic_top #(
  parameter int rgb_w = 6  // rgb pins per channel
) (
  input  wire                               clk_col4x_ntsc,
  input  wire                               rst_n,
  input  wire                               standard_sw,  // video standard switch
  input  wire                               ce,
  input  wire                               rw,
  input  wire  [vic_bus_pkg::addr_w-1:0]    adl,
  inout  tri   [vic_bus_pkg::data_w-1:0]    dbl,          // shared cpu data bus
  input  wire  [3:0]                        dbh,          // color data lines
  output wire                               irq,
  output wire                               hsync,
  output wire                               vsync,
  output wire                               active,
  output wire  [rgb_w-1:0]                  red,
  output wire  [rgb_w-1:0]                  green,
  output wire  [rgb_w-1:0]                  blue
);

  vic_video_pkg::chip_t                chip;
  wire [8:0]                           y_pos;
  wire                                 line_start;
  wire                                 frame_start;
  wire                                 in_window;
  wire [vic_bus_pkg::data_w-1:0]       dbo;
  wire                                 vic_write_db;
  wire [vic_bus_pkg::border_w-1:0]     border;

  chip_select chip_select_inst (
    .clk_col4x_ntsc (clk_col4x_ntsc),
    .rst_n          (rst_n),
    .standard_sw    (standard_sw),
    .frame_start    (frame_start),
    .chip           (chip)
  );

  raster_timing raster_timing_inst (
    .clk_col4x_ntsc (clk_col4x_ntsc),
    .rst_n          (rst_n),
    .chip           (chip),
    .x_pos          (),             // horizontal position not needed here
    .y_pos          (y_pos),
    .line_start     (line_start),
    .frame_start    (frame_start),
    .hsync          (hsync),
    .vsync          (vsync),
    .active         (active),
    .in_window      (in_window)
  );

  vic_registers vic_registers_inst (
    .clk_col4x_ntsc (clk_col4x_ntsc),
    .rst_n          (rst_n),
    .ce             (ce),
    .rw             (rw),
    .adl            (adl),
    .dbl            (dbl),
    .y_pos          (y_pos),
    .line_start     (line_start),
    .dbo            (dbo),
    .vic_write_db   (vic_write_db),
    .irq            (irq),
    .border         (border)
  );

  pixel_color #(
    .rgb_w (rgb_w)
  ) pixel_color_inst (
    .clk_col4x_ntsc (clk_col4x_ntsc),
    .rst_n          (rst_n),
    .border         (border),
    .color_nibble   (dbh),
    .active         (active),
    .in_window      (in_window),
    .red            (red),
    .green          (green),
    .blue           (blue)
  );

  // drive the bus only during a cpu read, else release it
  assign dbl = vic_write_db ? dbo : 'z;

endmodule

`default_nettype wire

/* vic_tb_sva.sv */
`timescale 1ns/100ps
`default_nettype none

// bus, interrupt and blanking properties of the video core
module vic_tb_sva #(
  parameter int rgb_w = 6
) (
  input wire             clk_col4x_ntsc,
  input wire             rst_n,
  input wire             ce,
  input wire             rw,
  input wire [5:0]       adl,
  input wire [7:0]       dbl,
  input wire [7:0]       dbo,
  input wire             vic_write_db,
  input wire             irq,
  input wire             active,
  input wire [rgb_w-1:0] red,
  input wire [rgb_w-1:0] green,
  input wire [rgb_w-1:0] blue
);

  logic ack_wr_d;  // ack write seen on the previous edge

  always_ff @(posedge clk_col4x_ntsc or negedge rst_n) begin
    if (!rst_n) begin
      ack_wr_d <= 1'b0;
    end else begin
      ack_wr_d <= !ce && !rw && (adl == vic_bus_pkg::reg_irq_status) && dbl[0];
    end
  end

  // read data reaches the pins with no second driver on the bus
  bus_read_data: assert property (@(posedge clk_col4x_ntsc) disable iff (!rst_n)
    vic_write_db |-> (dbl == dbo))
    else $error("dbl differs from the read data while the chip drives it");

  // flag clears on the write edge, pin follows one clock later
  irq_after_ack: assert property (@(posedge clk_col4x_ntsc) disable iff (!rst_n)
    ack_wr_d |=> irq)
    else $error("irq still low after an acknowledge write");

  rgb_blanked: assert property (@(posedge clk_col4x_ntsc) disable iff (!rst_n)
    !active |=> (red == '0 && green == '0 && blue == '0))
    else $error("rgb not zero one clock after active low");

endmodule

bind vic_top vic_tb_sva #(.rgb_w(rgb_w)) vic_tb_sva_inst (
  .clk_col4x_ntsc (clk_col4x_ntsc),
  .rst_n          (rst_n),
  .ce             (ce),
  .rw             (rw),
  .adl            (adl),
  .dbl            (dbl),
  .dbo            (dbo),
  .vic_write_db   (vic_write_db),
  .irq            (irq),
  .active         (active),
  .red            (red),
  .green          (green),
  .blue           (blue)
);

`default_nettype wire

/* vic_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_tb;

  localparam int rgb_w = 6;
  // three pal frames plus ten ntsc frames
  localparam int timeout_cycles = 3 * 312 * 504 + 10 * 263 * 520;

  // table operations
  localparam int op_write = 0;
  localparam int op_read = 1;
  localparam int op_wait_irq = 2;
  localparam int op_irq_level = 3;   // irq pin one clock later
  localparam int op_wait_flag = 4;   // poll status, irq must stay as expected
  localparam int op_set_sw = 5;
  localparam int op_measure_line = 6;
  localparam int op_measure_frame = 7;
  localparam int op_check_pixel = 8;  // addr 1 inside window, 0 border

  logic             clk_col4x_ntsc = 1'b0;
  logic             rst_n;
  logic             standard_sw;
  logic             ce;
  logic             rw;
  logic [5:0]       adl;
  logic [3:0]       dbh;
  logic [7:0]       drive_val;  // cpu write data
  logic             drive_en;
  wire  [7:0]       dbl;
  wire              irq;
  wire              hsync;
  wire              vsync;
  wire              active;
  wire  [rgb_w-1:0] red;
  wire  [rgb_w-1:0] green;
  wire  [rgb_w-1:0] blue;

  logic [31:0] lfsr = 32'hf9d8;
  int          cycles = 0;
  logic [31:0] tab_op[$];
  logic [31:0] tab_addr[$];
  logic [31:0] tab_data[$];
  logic [31:0] tab_exp[$];
  logic [3:0]  border_color;  // random border index
  logic [8:0]  cmp_line;      // random compare line, ntsc range
  logic [3:0]  pix_nibble;

  assign dbl = drive_en ? drive_val : 8'hzz;  // released outside writes

  vic_top #(
    .rgb_w (rgb_w)
  ) vic_top_inst (
    .clk_col4x_ntsc (clk_col4x_ntsc),
    .rst_n          (rst_n),
    .standard_sw    (standard_sw),
    .ce             (ce),
    .rw             (rw),
    .adl            (adl),
    .dbl            (dbl),
    .dbh            (dbh),
    .irq            (irq),
    .hsync          (hsync),
    .vsync          (vsync),
    .active         (active),
    .red            (red),
    .green          (green),
    .blue           (blue)
  );

  always #4 clk_col4x_ntsc = ~clk_col4x_ntsc;  // 8 ns period

  always @(posedge clk_col4x_ntsc) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: no result after %0d clock cycles", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // taps 32 22 2 1, shifting towards bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[0] ^ s[10] ^ s[30] ^ s[31], s[31:1]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};  // one step per bit taken
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] exp);
    tab_op.push_back(32'(op));
    tab_addr.push_back(addr);
    tab_data.push_back(data);
    tab_exp.push_back(exp);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
    @(posedge clk_col4x_ntsc);
    ce <= 1'b0;
    rw <= 1'b0;
    adl <= addr;
    drive_val <= data;
    drive_en <= 1'b1;
    @(posedge clk_col4x_ntsc);  // register takes the data here
    ce <= 1'b1;
    rw <= 1'b1;
    drive_en <= 1'b0;
  endtask

  task automatic read_reg(input logic [5:0] addr, input logic [31:0] exp);
    @(posedge clk_col4x_ntsc);
    ce <= 1'b0;
    rw <= 1'b1;
    adl <= addr;
    @(negedge clk_col4x_ntsc);
    check_value("dbl", 32'(dbl), exp);
    @(posedge clk_col4x_ntsc);
    ce <= 1'b1;
    @(negedge clk_col4x_ntsc);
    check_value("vic_write_db", 32'(vic_top_inst.vic_write_db), 32'd0);  // bus released
  endtask

  task automatic wait_irq_low();
    @(negedge clk_col4x_ntsc);
    while (irq) begin
      @(negedge clk_col4x_ntsc);
    end
  endtask

  task automatic wait_flag(input logic [31:0] exp_irq);
    logic seen;
    seen = 1'b0;
    @(posedge clk_col4x_ntsc);
    ce <= 1'b0;
    rw <= 1'b1;
    adl <= 6'h19;
    while (!seen) begin
      @(negedge clk_col4x_ntsc);
      check_value("irq", 32'(irq), exp_irq);
      seen = dbl[0];
    end
    @(negedge clk_col4x_ntsc);  // an enabled irq would be low by now
    check_value("irq", 32'(irq), exp_irq);
    @(posedge clk_col4x_ntsc);
    ce <= 1'b1;
  endtask

  // counts negedges until the chosen sync has the chosen edge
  task automatic wait_sync_edge(input logic use_vsync, input logic rise, output int n);
    logic prev;
    logic cur;
    n = 0;
    cur = use_vsync ? vsync : hsync;
    prev = cur;
    while (!(cur == rise && prev != rise)) begin
      @(negedge clk_col4x_ntsc);
      n++;
      prev = cur;
      cur = use_vsync ? vsync : hsync;
    end
  endtask

  task automatic measure_line(input logic [31:0] exp);
    int n;
    @(negedge clk_col4x_ntsc);
    wait_sync_edge(1'b0, 1'b1, n);
    wait_sync_edge(1'b0, 1'b1, n);  // one full line
    check_value("line length", 32'(n), exp);
  endtask

  task automatic measure_frame(input logic [31:0] exp);
    int n;
    repeat (4) @(negedge clk_col4x_ntsc);  // switch through the synchronizer
    wait_sync_edge(1'b1, 1'b1, n);          // frame start, new model applied
    wait_sync_edge(1'b1, 1'b0, n);
    wait_sync_edge(1'b1, 1'b0, n);
    check_value("frame length", 32'(n), exp);
  endtask

  task automatic pixel_probe(input logic want_window, input logic [3:0] nibble);
    logic        found;
    logic        in_win;
    logic        exp_act;
    logic [9:0]  x;
    logic [8:0]  y;
    logic [9:0]  x_end;  // first blanked clock at the line end
    logic [8:0]  y_end;  // first blanked line at the frame end
    logic [23:0] entry;
    found = 1'b0;
    in_win = 1'b0;
    x_end = standard_sw ? 10'd480 : 10'd496;  // line length less 24
    y_end = standard_sw ? 9'd296 : 9'd247;    // frame length less 16
    @(posedge clk_col4x_ntsc);
    dbh <= nibble;
    @(posedge clk_col4x_ntsc);
    while (!found) begin
      @(negedge clk_col4x_ntsc);
      x = vic_top_inst.raster_timing_inst.x_pos;
      y = vic_top_inst.raster_timing_inst.y_pos;
      in_win = (x >= 10'd128) && (x <= 10'd447) && (y >= 9'd51) && (y <= 9'd250);
      exp_act = (x >= 10'd64) && (x < x_end) && (y >= 9'd16) && (y < y_end);
      check_value("active", 32'(active), 32'(exp_act));
      found = exp_act && (in_win == want_window);
    end
    entry = vic_video_pkg::palette[in_win ? nibble : border_color];
    @(negedge clk_col4x_ntsc);  // rgb registered one clock behind
    check_value("rgb", 32'({red, green, blue}),
                32'({entry[23 -: rgb_w], entry[15 -: rgb_w], entry[7 -: rgb_w]}));
  endtask

  initial begin
    logic [31:0] rnd;
    rst_n = 1'b0;
    standard_sw = 1'b0;
    ce = 1'b1;
    rw = 1'b1;
    adl = '0;
    dbh = '0;
    drive_val = '0;
    drive_en = 1'b0;

    rand_bits(4, rnd);
    border_color = rnd[3:0];
    rand_bits(9, rnd);
    cmp_line = 9'(rnd % 32'd263);
    rand_bits(4, rnd);
    pix_nibble = rnd[3:0];

    add_row(op_write, 32'h20, 32'(border_color), 0);
    add_row(op_read, 32'h20, 0, 32'(8'hf0 | border_color));  // upper nibble reads ones
    add_row(op_read, 32'h3f, 0, 32'hff);                      // unmapped
    add_row(op_write, 32'h11, 32'({cmp_line[8], 7'b0}), 0);
    add_row(op_write, 32'h12, 32'(cmp_line[7:0]), 0);
    add_row(op_write, 32'h19, 1, 0);  // flag left from the line 0 match after reset
    add_row(op_write, 32'h1a, 1, 0);
    add_row(op_wait_irq, 0, 0, 0);
    add_row(op_read, 32'h12, 0, 32'(cmp_line[7:0]));
    add_row(op_read, 32'h11, 0, 32'({cmp_line[8], 7'b0}));
    add_row(op_write, 32'h19, 1, 0);  // ack
    add_row(op_irq_level, 0, 0, 1);
    add_row(op_read, 32'h19, 0, 32'hf0);
    add_row(op_write, 32'h1a, 0, 0);
    add_row(op_read, 32'h1a, 0, 32'hf0);
    add_row(op_wait_flag, 0, 0, 1);   // flag sets, irq masked
    add_row(op_measure_line, 0, 0, 520);
    add_row(op_set_sw, 0, 1, 0);
    add_row(op_measure_frame, 0, 0, 312 * 504);
    add_row(op_measure_line, 0, 0, 504);
    add_row(op_check_pixel, 0, 32'(~border_color), 0);  // dbh must be ignored here
    add_row(op_check_pixel, 1, 32'(pix_nibble), 0);

    repeat (8) @(posedge clk_col4x_ntsc);
    rst_n <= 1'b1;

    for (int i = 0; i < tab_op.size(); i++) begin
      case (tab_op[i])
        op_write:         write_reg(tab_addr[i][5:0], tab_data[i][7:0]);
        op_read:          read_reg(tab_addr[i][5:0], tab_exp[i]);
        op_wait_irq:      wait_irq_low();
        op_irq_level: begin
          @(posedge clk_col4x_ntsc);
          @(negedge clk_col4x_ntsc);
          check_value("irq", 32'(irq), tab_exp[i]);
        end
        op_wait_flag:     wait_flag(tab_exp[i]);
        op_set_sw: begin
          @(posedge clk_col4x_ntsc);
          standard_sw <= tab_data[i][0];
        end
        op_measure_line:  measure_line(tab_exp[i]);
        op_measure_frame: measure_frame(tab_exp[i]);
        op_check_pixel:   pixel_probe(tab_addr[i][0], tab_data[i][3:0]);
        default: begin
          $display("unknown operation in table row %0d", i);
          $display("RESULT: FAIL");
          $fatal(1, "bad table row");
        end
      endcase
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
vic_bus_pkg.sv
vic_video_pkg.sv
chip_select.sv
raster_timing.sv
vic_registers.sv
pixel_color.sv
vic_top.sv
vic_tb_sva.sv
vic_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the testbench with verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --timescale 1ns/100ps --top-module vic_tb \
  -f vlog.f -o vic_sim > build.log 2>&1 \
  && ./obj_dir/vic_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"

grep -qx "RESULT: PASS" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
